// File: common/ntt_ctrl_params.svh
`ifndef NTT_CTRL_PARAMS_SVH
`define NTT_CTRL_PARAMS_SVH

// counter width
`define NTT_D_WIDTH 8

// butterflies per pass, iterations 0 to 2
`define NTT_BU_TOTAL 64

// last-stage count bound
`define NTT_BU_TOTAL_K2 8

// butterflies per group
`define NTT_ITE_0 64
`define NTT_ITE_1 4
`define NTT_ITE_2 32
`define NTT_ITE_3 8

// groups per iteration
`define NTT_GROUPS_1 16
`define NTT_GROUPS_2 2

// drain bounds, phase lasts bound + 1 cycles
`define NTT_DRAIN_0 24
`define NTT_DRAIN_1 24
`define NTT_DRAIN_2 24
`define NTT_DRAIN_3 8

// twiddle depth base of the last stage
`define NTT_LAST_L 4

// idle wait before a run starts
`define NTT_INIT_WAIT 1

`endif

// File: common/ntt_ctrl_pkg.sv
`include "ntt_ctrl_params.svh"

package ntt_ctrl_pkg;

    typedef enum logic [3:0] {
        RESET,
        IDLE,
        ITE0,
        DRAIN0,
        ITE1,
        DRAIN1,
        ITE2,
        DRAIN2,
        ITE3,
        DRAIN3,
        FINISH
    } phase_e;

    typedef logic [`NTT_D_WIDTH-1:0] cnt_t;
    typedef logic [2:0] depth_t;

    // upstream levels, sampled every cycle
    typedef struct packed {
        logic       bn_ma_out_en;
        logic       r_enable_out;
        logic [1:0] ntt_done;
    } ntt_status_t;

    typedef struct packed {
        logic r_enable;
        logic w_enable;
        logic ntt_enable;
    } mem_strobe_t;

    typedef struct packed {
        logic agu_enable;
        logic agu_enable_k2;
        logic last_stage;
    } agu_ctrl_t;

    typedef struct packed {
        logic   tf_ren;
        logic   tf_wen;
        depth_t it_depth_cnt;
    } tf_ctrl_t;

    // pass counter state seen by sequencer and twiddle control
    typedef struct packed {
        logic   pass_done;
        logic   k2_done;
        cnt_t   bu_cnt;
        cnt_t   bu_group_cnt;
        depth_t ite_stage;
        cnt_t   k2_cnt;
    } pass_count_t;

endpackage

// File: ntt_ctrl/stage_sequencer.sv
`include "ntt_ctrl_params.svh"

module stage_sequencer import ntt_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  ntt_status_t status,
    input  pass_count_t counts,
    output phase_e      phase,
    output logic        tf_ren,
    output mem_strobe_t mem,
    output agu_ctrl_t   agu,
    output logic        done
);

    localparam cnt_t init_wait = cnt_t'(`NTT_INIT_WAIT);

    phase_e phase_nxt;
    cnt_t   init_cnt;
    cnt_t   drain_cnt;
    cnt_t   drain_bound;
    logic   init_done;
    logic   drain_end;
    logic   wb_hit;

    assign init_done = (phase == IDLE) && (init_cnt == init_wait);
    assign drain_end = (drain_cnt == drain_bound);
    assign wb_hit    = (status.ntt_done == 2'd1);

    always_comb begin
        case (phase)
            DRAIN0:  drain_bound = cnt_t'(`NTT_DRAIN_0);
            DRAIN1:  drain_bound = cnt_t'(`NTT_DRAIN_1);
            DRAIN2:  drain_bound = cnt_t'(`NTT_DRAIN_2);
            DRAIN3:  drain_bound = cnt_t'(`NTT_DRAIN_3);
            default: drain_bound = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= RESET;
        end else begin
            phase <= phase_nxt;
        end
    end

    // counts only in idle so every run waits the same
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            init_cnt <= '0;
        end else if (phase == IDLE && !init_done) begin
            init_cnt <= init_cnt + cnt_t'(1);
        end else begin
            init_cnt <= '0;
        end
    end

    // shared drain counter restarts on every phase change
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            drain_cnt <= '0;
        end else if (phase_nxt != phase) begin
            drain_cnt <= '0;
        end else if (phase inside {DRAIN0, DRAIN1, DRAIN2, DRAIN3}) begin
            drain_cnt <= drain_cnt + cnt_t'(1);
        end
    end

    always_comb begin
        phase_nxt = phase;
        case (phase)
            RESET:  phase_nxt = IDLE;
            IDLE:   if (init_done) phase_nxt = ITE0;
            ITE0:   if (counts.pass_done) phase_nxt = DRAIN0;
            DRAIN0: if (drain_end) phase_nxt = ITE1;
            ITE1:   if (counts.pass_done) phase_nxt = DRAIN1;
            DRAIN1: if (drain_end) phase_nxt = ITE2;
            ITE2:   if (counts.pass_done) phase_nxt = DRAIN2;
            DRAIN2: if (drain_end) phase_nxt = ITE3;
            ITE3:   if (counts.k2_done) phase_nxt = DRAIN3;
            DRAIN3: if (drain_end) phase_nxt = FINISH;
            FINISH: phase_nxt = IDLE;
            default: phase_nxt = RESET;
        endcase
    end

    // strobe decode
    always_comb begin
        tf_ren   = 1'b0;
        mem      = '0;
        agu      = '0;
        done     = 1'b0;
        case (phase)
            ITE0, ITE1, ITE2, ITE3: begin
                tf_ren         = status.bn_ma_out_en;
                mem.r_enable   = status.bn_ma_out_en;
                mem.w_enable   = wb_hit;
                mem.ntt_enable = status.r_enable_out;
            end
            DRAIN0, DRAIN1, DRAIN2: begin
                mem.w_enable   = 1'b1;
                mem.ntt_enable = status.r_enable_out;
            end
            DRAIN3: begin
                mem.w_enable   = wb_hit;
                mem.ntt_enable = status.r_enable_out;
            end
            FINISH: done = 1'b1;
            default: ;
        endcase
        agu.agu_enable    = (phase inside {ITE0, ITE1, ITE2});
        agu.agu_enable_k2 = (phase == ITE3);
        agu.last_stage    = (phase inside {ITE3, DRAIN3});
    end

    // the pass counter may only finish a pass on a read
    a_end_on_read: assert property (
        @(posedge clk) disable iff (rst) (counts.pass_done || counts.k2_done) |-> tf_ren
    );

    a_done_single: assert property (
        @(posedge clk) disable iff (rst) done |=> !done
    );

endmodule

// File: ntt_ctrl/pass_counter.sv
`include "ntt_ctrl_params.svh"

module pass_counter import ntt_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  phase_e      phase,
    input  logic        tf_ren,
    output pass_count_t counts
);

    localparam cnt_t pass_last = cnt_t'(`NTT_BU_TOTAL - 1);
    localparam cnt_t k2_last   = cnt_t'(`NTT_BU_TOTAL_K2);

    cnt_t   pass_cnt;
    cnt_t   k2_cnt;
    cnt_t   bu_cnt;
    cnt_t   group_cnt;
    cnt_t   bu_last;
    cnt_t   group_last;
    depth_t ite_stage;
    logic   in_pass;
    logic   in_ite;

    assign in_pass = (phase inside {ITE0, ITE1, ITE2});
    assign in_ite  = in_pass || (phase == ITE3);

    // pass count and stage index
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pass_cnt  <= '0;
            ite_stage <= '0;
        end else if (phase == IDLE) begin
            pass_cnt  <= '0;
            ite_stage <= '0;
        end else if (in_pass && tf_ren) begin
            if (pass_cnt == pass_last) begin
                pass_cnt <= '0;
                if (ite_stage != 3'd3) begin
                    ite_stage <= ite_stage + 3'd1;
                end
            end else begin
                pass_cnt <= pass_cnt + cnt_t'(1);
            end
        end
    end

    // last-stage reads
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            k2_cnt <= '0;
        end else if (phase == IDLE) begin
            k2_cnt <= '0;
        end else if (phase == ITE3 && tf_ren) begin
            k2_cnt <= (k2_cnt == k2_last) ? '0 : k2_cnt + cnt_t'(1);
        end
    end

    // group geometry of each iteration
    always_comb begin
        case (phase)
            ITE0: begin
                bu_last    = cnt_t'(`NTT_ITE_0 - 1);
                group_last = '0;
            end
            ITE1: begin
                bu_last    = cnt_t'(`NTT_ITE_1 - 1);
                group_last = cnt_t'(`NTT_GROUPS_1 - 1);
            end
            ITE2: begin
                bu_last    = cnt_t'(`NTT_ITE_2 - 1);
                group_last = cnt_t'(`NTT_GROUPS_2 - 1);
            end
            ITE3: begin
                bu_last    = cnt_t'(`NTT_ITE_3 - 1);
                group_last = '0;
            end
            default: begin
                bu_last    = '0;
                group_last = '0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bu_cnt    <= '0;
            group_cnt <= '0;
        end else if (!in_ite) begin
            bu_cnt    <= '0;
            group_cnt <= '0;
        end else if (tf_ren) begin
            if (bu_cnt == bu_last) begin
                bu_cnt    <= '0;
                group_cnt <= (group_cnt == group_last) ? '0 : group_cnt + cnt_t'(1);
            end else begin
                bu_cnt <= bu_cnt + cnt_t'(1);
            end
        end
    end

    always_comb begin
        counts.pass_done    = in_pass && tf_ren && (pass_cnt == pass_last);
        counts.k2_done      = (phase == ITE3) && tf_ren && (k2_cnt == k2_last);
        counts.bu_cnt       = bu_cnt;
        counts.bu_group_cnt = group_cnt;
        counts.ite_stage    = ite_stage;
        counts.k2_cnt       = k2_cnt;
    end

endmodule

// File: ntt_ctrl/twiddle_ctrl.sv
`include "ntt_ctrl_params.svh"

module twiddle_ctrl import ntt_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  phase_e      phase,
    input  logic        tf_ren,
    input  pass_count_t counts,
    output logic        tf_wen,
    output depth_t      it_depth_cnt
);

    localparam depth_t last_l   = depth_t'(`NTT_LAST_L);
    localparam depth_t last_top = depth_t'(`NTT_LAST_L + 3);
    localparam cnt_t   wen_bu_1 = cnt_t'(`NTT_ITE_1 - 2);
    localparam cnt_t   grp_1    = cnt_t'(`NTT_GROUPS_1 - 1);

    depth_t     depth2;
    logic [1:0] depth2_idx;
    depth_t     depth3;

    // iteration 2 walks 2, 3, 3, 2 one read behind its index
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            depth2     <= 3'd2;
            depth2_idx <= '0;
        end else if (phase == IDLE) begin
            depth2     <= 3'd2;
            depth2_idx <= '0;
        end else if (phase == ITE2 && tf_ren) begin
            depth2_idx <= depth2_idx + 2'd1;
            if (depth2_idx == 2'd1 || depth2_idx == 2'd2) begin
                depth2 <= counts.ite_stage + 3'd1;
            end else begin
                depth2 <= counts.ite_stage;
            end
        end
    end

    // iteration 3 cycles last_l .. last_l+3
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            depth3 <= last_l;
        end else if (phase == IDLE) begin
            depth3 <= last_l;
        end else if (phase == ITE3 && tf_ren) begin
            depth3 <= (depth3 == last_top) ? last_l : depth3 + 3'd1;
        end
    end

    always_comb begin
        it_depth_cnt = '0;
        tf_wen       = 1'b0;
        case (phase)
            ITE0: if (tf_ren) it_depth_cnt = counts.ite_stage;
            ITE1: begin
                if (tf_ren) it_depth_cnt = counts.ite_stage;
                tf_wen = (counts.bu_cnt == wen_bu_1) && (counts.bu_group_cnt != grp_1);
            end
            ITE2: begin
                if (tf_ren) it_depth_cnt = depth2;
                tf_wen = (counts.bu_cnt == '0);
            end
            ITE3: begin
                if (tf_ren) it_depth_cnt = depth3;
                tf_wen = (counts.k2_cnt >= cnt_t'(2));
            end
            DRAIN0, DRAIN1, DRAIN2: it_depth_cnt = counts.ite_stage;
            DRAIN3: it_depth_cnt = last_l;
            default: ;
        endcase
    end

    // iteration 2 reads only depths 2 and 3
    a_ite2_depth: assert property (
        @(posedge clk) disable iff (rst)
            (phase == ITE2 && tf_ren) |-> (it_depth_cnt inside {3'd2, 3'd3})
    );

endmodule

// File: rtl/ntt_ctrl_top.sv
module ntt_ctrl_top import ntt_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  ntt_status_t status,
    output mem_strobe_t mem,
    output agu_ctrl_t   agu,
    output tf_ctrl_t    tf,
    output logic        done
);

    phase_e      phase;
    pass_count_t counts;
    logic        tf_ren;
    logic        tf_wen;
    depth_t      it_depth_cnt;

    stage_sequencer u_seq (
        .clk    (clk),
        .rst    (rst),
        .status (status),
        .counts (counts),
        .phase  (phase),
        .tf_ren (tf_ren),
        .mem    (mem),
        .agu    (agu),
        .done   (done)
    );

    pass_counter u_cnt (
        .clk    (clk),
        .rst    (rst),
        .phase  (phase),
        .tf_ren (tf_ren),
        .counts (counts)
    );

    // twiddle depth and write strobe
    twiddle_ctrl u_tf (
        .clk          (clk),
        .rst          (rst),
        .phase        (phase),
        .tf_ren       (tf_ren),
        .counts       (counts),
        .tf_wen       (tf_wen),
        .it_depth_cnt (it_depth_cnt)
    );

    assign tf.tf_ren       = tf_ren;
    assign tf.tf_wen       = tf_wen;
    assign tf.it_depth_cnt = it_depth_cnt;

endmodule

// File: sim/tb_ntt_ctrl.sv
`include "ntt_ctrl_params.svh"

module tb_ntt_ctrl
    import ntt_ctrl_pkg::*;
();

    logic        clk;
    logic        rst;
    ntt_status_t status;
    mem_strobe_t mem;
    agu_ctrl_t   agu;
    tf_ctrl_t    tf;
    logic        done;

    logic [31:0] lfsr;
    logic        stall_mode;
    logic        wb_mode;
    string       cur_test;
    int          err_count;
    int          errs_start;
    int          tests_run;
    int          tests_failed;
    logic        aborted;

    // phase as seen from the outputs, plus per-run statistics
    phase_e      cur_phase;
    logic        rst_q;
    int          ridx;
    int          idle_run;
    int          last_idle;
    int          reads;
    int          dones;
    int          cyc [16];
    int          wen [16];

    ntt_ctrl_top dut0 (
        .clk    (clk),
        .rst    (rst),
        .status (status),
        .mem    (mem),
        .agu    (agu),
        .tf     (tf),
        .done   (done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic rand_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    task automatic compare_mem(string what, mem_strobe_t exp, mem_strobe_t act);
        if (exp !== act) begin
            err_count++;
            $display("Fail %s: %s expected %b actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic compare_agu(string what, agu_ctrl_t exp, agu_ctrl_t act);
        if (exp !== act) begin
            err_count++;
            $display("Fail %s: %s expected %b actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic compare_tf(string what, tf_ctrl_t exp, tf_ctrl_t act);
        if (exp !== act) begin
            err_count++;
            $display("Fail %s: %s expected %b actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic compare_cnt(string what, cnt_t exp, cnt_t act);
        if (exp !== act) begin
            err_count++;
            $display("Fail %s: %s expected %0d actual %0d", cur_test, what, exp, act);
        end
    endtask

    task automatic compare_bit(string what, logic exp, logic act);
        if (exp !== act) begin
            err_count++;
            $display("Fail %s: %s expected %b actual %b", cur_test, what, exp, act);
        end
    endtask

    // output class matches phase p
    function automatic logic fits(phase_e p);
        case (p)
            ITE0, ITE1, ITE2: return agu.agu_enable;
            ITE3:             return agu.agu_enable_k2;
            DRAIN3:           return agu.last_stage && !agu.agu_enable_k2;
            FINISH:           return done;
            default:          return !agu.agu_enable && !agu.agu_enable_k2 &&
                                     !agu.last_stage && !done;
        endcase
    endfunction

    // r is the number of reads already made in this iteration
    function automatic tf_ctrl_t tf_expect(phase_e p, logic ren, int r);
        tf_ctrl_t t;
        t = '0;
        t.tf_ren = ren;
        case (p)
            ITE1: begin
                t.tf_wen = (r % `NTT_ITE_1 == `NTT_ITE_1 - 2) &&
                           (r / `NTT_ITE_1 != `NTT_GROUPS_1 - 1);
                if (ren) t.it_depth_cnt = 3'd1;
            end
            ITE2: begin
                t.tf_wen = (r % `NTT_ITE_2 == 0);
                if (ren && r > 0 && ((r - 1) % 4 == 1 || (r - 1) % 4 == 2)) begin
                    t.it_depth_cnt = 3'd3;
                end else if (ren) begin
                    t.it_depth_cnt = 3'd2;
                end
            end
            ITE3: begin
                t.tf_wen = (r >= 2);
                if (ren) t.it_depth_cnt = depth_t'(`NTT_LAST_L + r % 4);
            end
            DRAIN0:  t.it_depth_cnt = 3'd1;
            DRAIN1:  t.it_depth_cnt = 3'd2;
            DRAIN2:  t.it_depth_cnt = 3'd3;
            DRAIN3:  t.it_depth_cnt = depth_t'(`NTT_LAST_L);
            default: t.it_depth_cnt = 3'd0;
        endcase
        return t;
    endfunction

    task automatic drive_inputs();
        status.bn_ma_out_en = stall_mode ? rand_bit() : 1'b1;
        if (wb_mode) begin
            status.r_enable_out = rand_bit();
            status.ntt_done[0]  = rand_bit();
            status.ntt_done[1]  = rand_bit();
        end else begin
            status.r_enable_out = 1'b1;
            status.ntt_done     = 2'd1;
        end
    endtask

    // sample at the rising edge, drive at the falling edge
    task automatic step();
        phase_e      tp;
        mem_strobe_t em;
        agu_ctrl_t   ea;
        logic        ite;
        logic        ren;
        @(posedge clk);
        if (rst || (cur_phase == RESET && rst_q)) tp = RESET;
        else if (cur_phase inside {RESET, FINISH}) tp = IDLE;
        else if (fits(cur_phase)) tp = cur_phase;
        else tp = phase_e'(cur_phase + 1);
        if (tp != cur_phase) begin
            ridx = 0;
            if (tp == IDLE) idle_run = 0;
            if (tp == ITE0) begin
                foreach (cyc[i]) begin
                    cyc[i] = 0;
                    wen[i] = 0;
                end
                reads     = 0;
                dones     = 0;
                last_idle = idle_run;
            end
        end
        ite = tp inside {ITE0, ITE1, ITE2, ITE3};
        ren = ite && status.bn_ma_out_en;
        em = '0;
        em.r_enable = ren;
        if (ite || tp == DRAIN3) em.w_enable = (status.ntt_done == 2'd1);
        else if (tp inside {DRAIN0, DRAIN1, DRAIN2}) em.w_enable = 1'b1;
        if (ite || tp inside {DRAIN0, DRAIN1, DRAIN2, DRAIN3}) begin
            em.ntt_enable = status.r_enable_out;
        end
        ea.agu_enable    = tp inside {ITE0, ITE1, ITE2};
        ea.agu_enable_k2 = (tp == ITE3);
        ea.last_stage    = tp inside {ITE3, DRAIN3};
        compare_mem("mem", em, mem);
        compare_agu("agu", ea, agu);
        compare_tf("tf", tf_expect(tp, ren, ridx), tf);
        compare_bit("done", tp == FINISH, done);
        cyc[tp]++;
        if (tf.tf_wen) wen[tp]++;
        if (tf.tf_ren) reads++;
        if (done) dones++;
        if (tp == IDLE) idle_run++;
        if (ren) ridx++;
        cur_phase = tp;
        rst_q     = rst;
        @(negedge clk);
        drive_inputs();
    endtask

    task automatic begin_test(string name);
        cur_test   = name;
        errs_start = err_count;
        tests_run++;
    endtask

    task automatic end_test();
        if (err_count == errs_start && !aborted) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", cur_test, err_count - errs_start);
        end
    endtask

    task automatic run_once(logic stall, logic wb);
        int n;
        stall_mode = stall;
        wb_mode    = wb;
        n = 0;
        do begin
            step();
            n++;
        end while (cur_phase != FINISH && n < 4000);
        if (cur_phase != FINISH) begin
            aborted = 1'b1;
            $display("timeout in test %s: no done pulse within %0d cycles", cur_test, n);
        end
    endtask

    task automatic check_timing(logic held);
        compare_cnt("done pulses", cnt_t'(1), cnt_t'(dones));
        compare_cnt("reads per run", cnt_t'(3 * `NTT_BU_TOTAL + `NTT_BU_TOTAL_K2 + 1),
                    cnt_t'(reads));
        compare_cnt("idle cycles", cnt_t'(2), cnt_t'(last_idle));
        compare_cnt("drain0 cycles", cnt_t'(`NTT_DRAIN_0 + 1), cnt_t'(cyc[DRAIN0]));
        compare_cnt("drain1 cycles", cnt_t'(`NTT_DRAIN_1 + 1), cnt_t'(cyc[DRAIN1]));
        compare_cnt("drain2 cycles", cnt_t'(`NTT_DRAIN_2 + 1), cnt_t'(cyc[DRAIN2]));
        compare_cnt("drain3 cycles", cnt_t'(`NTT_DRAIN_3 + 1), cnt_t'(cyc[DRAIN3]));
        if (held) begin
            compare_cnt("ite0 cycles", cnt_t'(`NTT_BU_TOTAL), cnt_t'(cyc[ITE0]));
            compare_cnt("ite1 cycles", cnt_t'(`NTT_BU_TOTAL), cnt_t'(cyc[ITE1]));
            compare_cnt("ite2 cycles", cnt_t'(`NTT_BU_TOTAL), cnt_t'(cyc[ITE2]));
            compare_cnt("ite3 cycles", cnt_t'(`NTT_BU_TOTAL_K2 + 1), cnt_t'(cyc[ITE3]));
        end
    endtask

    task automatic check_twiddle();
        compare_cnt("ite1 writes", cnt_t'(`NTT_GROUPS_1 - 1), cnt_t'(wen[ITE1]));
        compare_cnt("ite2 writes", cnt_t'(`NTT_GROUPS_2), cnt_t'(wen[ITE2]));
        compare_cnt("ite3 writes", cnt_t'(`NTT_BU_TOTAL_K2 - 1), cnt_t'(wen[ITE3]));
    endtask

    task automatic test_reset();
        int n;
        begin_test("reset");
        rst = 1'b1;
        repeat (4) step();
        rst = 1'b0;
        n = 0;
        do begin
            step();
            n++;
        end while (cur_phase != ITE0 && n < 20);
        if (cur_phase != ITE0) begin
            aborted = 1'b1;
            $display("timeout in test %s: first iteration never started", cur_test);
        end else begin
            compare_cnt("cycles to first read", cnt_t'(4), cnt_t'(n));
        end
        end_test();
    endtask

    task automatic test_full_run();
        begin_test("full_run");
        run_once(1'b0, 1'b0);
        if (!aborted) check_timing(1'b1);
        end_test();
    endtask

    task automatic test_stalls();
        begin_test("stalls");
        run_once(1'b1, 1'b0);
        if (!aborted) check_timing(1'b0);
        end_test();
    endtask

    task automatic test_writeback();
        begin_test("writeback");
        run_once(1'b0, 1'b1);
        if (!aborted) check_timing(1'b1);
        end_test();
    endtask

    task automatic test_twiddle();
        begin_test("twiddle");
        run_once(1'b0, 1'b0);
        if (!aborted) check_twiddle();
        end_test();
    endtask

    task automatic test_repeat();
        begin_test("repeat");
        repeat (2) begin
            run_once(1'b0, 1'b0);
            if (!aborted) begin
                check_timing(1'b1);
                check_twiddle();
            end
        end
        end_test();
    endtask

    initial begin
        rst          = 1'b1;
        status       = '0;
        lfsr         = 32'h8ead_f1e6;
        stall_mode   = 1'b0;
        wb_mode      = 1'b0;
        err_count    = 0;
        tests_run    = 0;
        tests_failed = 0;
        aborted      = 1'b0;
        cur_phase    = RESET;
        rst_q        = 1'b1;
        ridx         = 0;
        idle_run     = 0;
        last_idle    = 0;
        reads        = 0;
        dones        = 0;
        test_reset();
        if (!aborted) test_full_run();
        if (!aborted) test_stalls();
        if (!aborted) test_writeback();
        if (!aborted) test_twiddle();
        if (!aborted) test_repeat();
        $display("summary: %0d tests, %0d failed, %0d failing checks",
                 tests_run, tests_failed, err_count);
        if (aborted || tests_failed != 0 || err_count != 0) begin
            $display("TEST RESULT: FAIL");
        end else begin
            $display("TEST RESULT: PASS");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+common
common/ntt_ctrl_pkg.sv
ntt_ctrl/stage_sequencer.sv
ntt_ctrl/pass_counter.sv
ntt_ctrl/twiddle_ctrl.sv
rtl/ntt_ctrl_top.sv
sim/tb_ntt_ctrl.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_ntt_ctrl -f flist.f -o tb_ntt_ctrl
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/tb_ntt_ctrl > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
